// ==== bus_arbiter.sv ====
//==================================================
// Fixed priority arbiter for the shared RAM.
// dbus beats ibus beats host. The owner is locked
// until the RAM answers, then one idle cycle.
//==================================================
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input wire i_clock,
	input wire i_reset,

	input wire i_dbus_request,
	input wire cpu_pkg::bus_req_t i_dbus_req,
	output logic o_dbus_ready,
	output cpu_pkg::word_t o_dbus_rdata,

	input wire i_ibus_request,
	input wire cpu_pkg::bus_req_t i_ibus_req,
	output logic o_ibus_ready,
	output cpu_pkg::word_t o_ibus_rdata,

	input wire i_host_request,
	input wire cpu_pkg::bus_req_t i_host_req,
	output logic o_host_ready,
	output cpu_pkg::word_t o_host_rdata,

	output logic o_mem_request,
	output cpu_pkg::bus_req_t o_mem_req,
	input wire i_mem_ready,
	input wire cpu_pkg::word_t i_mem_rdata
);
	import cpu_pkg::*;

	master_e owner;

	// Grant only from idle, release on the RAM's ready pulse
	always_ff @(posedge i_clock) begin
		if (i_reset)
			owner <= M_NONE;
		else if (owner == M_NONE) begin
			if (i_dbus_request)
				owner <= M_DBUS;
			else if (i_ibus_request)
				owner <= M_IBUS;
			else if (i_host_request)
				owner <= M_HOST;
		end else if (i_mem_ready)
			owner <= M_NONE;
	end

	always_comb begin
		o_mem_request = 1'b0;
		o_mem_req = '0;
		case (owner)
			M_DBUS: begin
				o_mem_request = i_dbus_request;
				o_mem_req = i_dbus_req;
			end
			M_IBUS: begin
				o_mem_request = i_ibus_request;
				o_mem_req = i_ibus_req;
			end
			M_HOST: begin
				o_mem_request = i_host_request;
				o_mem_req = i_host_req;
			end
			default: ;
		endcase
	end

	// Response goes back to the owner only
	assign o_dbus_ready = i_mem_ready && (owner == M_DBUS);
	assign o_ibus_ready = i_mem_ready && (owner == M_IBUS);
	assign o_host_ready = i_mem_ready && (owner == M_HOST);
	assign o_dbus_rdata = (owner == M_DBUS) ? i_mem_rdata : '0;
	assign o_ibus_rdata = (owner == M_IBUS) ? i_mem_rdata : '0;
	assign o_host_rdata = (owner == M_HOST) ? i_mem_rdata : '0;

	// Owning master keeps requesting up to and including its ready cycle
	a_owner_requests: assert property (@(posedge i_clock) disable iff (i_reset)
		owner != M_NONE |-> o_mem_request);
	a_ready_owned: assert property (@(posedge i_clock) disable iff (i_reset)
		i_mem_ready |-> owner != M_NONE);

endmodule

`default_nettype wire

// ==== cpu_core.sv ====
//==================================================
// Multi-cycle RV32I subset core, one instruction in
// flight. Fetches over the instruction bus, loads and
// stores over the data bus, halts on ECALL or fault.
//==================================================
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
	input wire i_clock,
	input wire i_reset,
	input wire i_run,

	// Instruction bus
	output logic o_ibus_request,
	input wire i_ibus_ready,
	output cpu_pkg::bus_req_t o_ibus_req,
	input wire cpu_pkg::word_t i_ibus_rdata,

	// Data bus
	output logic o_dbus_request,
	input wire i_dbus_ready,
	output cpu_pkg::bus_req_t o_dbus_req,
	input wire cpu_pkg::word_t i_dbus_rdata,

	// Debug
	output logic o_busy,
	output logic o_halted,
	output logic o_fault,
	output cpu_pkg::word_t o_retired
);
	import cpu_pkg::*;

	core_state_e state;
	addr_t pc;
	addr_t next_pc;
	word_t instruction;
	word_t result;
	logic fetch_hold;
	decode_t dec;
	word_t rs1;
	word_t rs2;
	word_t alu_b;
	word_t alu_out;
	logic branch_taken;

	//==================================================
	// Decode and registers

	cpu_decode decode_i (
		.i_instruction(instruction),
		.o_decode(dec)
	);

	cpu_registers registers_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rs1_idx(dec.rs1),
		.i_rs2_idx(dec.rs2),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.i_write(state == ST_WRITEBACK && dec.reg_write),
		.i_rd_idx(dec.rd),
		.i_rd_data(result)
	);

	//==================================================
	// ALU

	always_comb begin
		alu_b = dec.use_imm ? dec.imm : rs2;
		case (dec.alu_op)
			ALU_SUB: alu_out = rs1 - alu_b;
			ALU_PASS_B: alu_out = alu_b;
			default: alu_out = rs1 + alu_b;
		endcase
	end

	// BEQ taken when rs1 - rs2 is zero
	assign branch_taken = dec.is_branch && (alu_out == '0);

	//==================================================
	// Sequencer

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_FETCH;
			pc <= RESET_VECTOR;
			fetch_hold <= 1'b0;
			o_fault <= 1'b0;
			o_retired <= '0;
		end else begin
			// Keeps a started fetch alive if i_run drops
			fetch_hold <= o_ibus_request && !i_ibus_ready;
			case (state)
				ST_FETCH: if (i_ibus_ready) state <= ST_EXECUTE;
				ST_EXECUTE: begin
					if (dec.illegal) begin
						state <= ST_HALT;
						o_fault <= 1'b1;
					end else if (dec.is_ecall)
						state <= ST_HALT;
					else if (dec.is_load || dec.is_store)
						state <= ST_MEMORY;
					else
						state <= ST_WRITEBACK;
				end
				ST_MEMORY: if (i_dbus_ready) state <= ST_WRITEBACK;
				ST_WRITEBACK: begin
					pc <= next_pc;
					o_retired <= o_retired + 32'd1;
					state <= ST_FETCH;
				end
				default: state <= ST_HALT;
			endcase
		end
	end

	// Instruction, result and target latches
	always_ff @(posedge i_clock) begin
		if (state == ST_FETCH && i_ibus_ready)
			instruction <= i_ibus_rdata;
		if (state == ST_EXECUTE) begin
			result <= dec.is_jal ? pc + 32'd4 : alu_out;
			next_pc <= (dec.is_jal || branch_taken) ? pc + dec.imm : pc + 32'd4;
		end
		if (state == ST_MEMORY && i_dbus_ready && dec.is_load)
			result <= i_dbus_rdata;
	end

	//==================================================
	// Bus requests and status

	assign o_ibus_request = (state == ST_FETCH) && (i_run || fetch_hold);
	assign o_ibus_req = '{rw: 1'b0, address: pc, wdata: '0};
	// Address was computed into result during execute
	assign o_dbus_request = (state == ST_MEMORY);
	assign o_dbus_req = '{rw: dec.is_store, address: result, wdata: rs2};

	assign o_halted = (state == ST_HALT);
	assign o_busy = o_ibus_request || (state inside {ST_EXECUTE, ST_MEMORY, ST_WRITEBACK});

	// A ready only ever answers an outstanding request
	a_ready_requested: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_ibus_ready && !o_ibus_request) && !(i_dbus_ready && !o_dbus_request));
	a_ibus_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		o_ibus_request && !i_ibus_ready |=> o_ibus_request && $stable(o_ibus_req));
	a_dbus_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		o_dbus_request && !i_dbus_ready |=> o_dbus_request && $stable(o_dbus_req));

endmodule

`default_nettype wire

// ==== cpu_decode.sv ====
//==================================================
// Combinational decoder for the supported subset.
// Anything outside LUI, ADDI, ADD, SUB, LW, SW, BEQ,
// JAL and ECALL comes out with illegal set.
//==================================================
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
	input wire cpu_pkg::word_t i_instruction,
	output cpu_pkg::decode_t o_decode
);
	import cpu_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;

	assign opcode = i_instruction[6:0];
	assign funct3 = i_instruction[14:12];
	assign funct7 = i_instruction[31:25];

	// Sign-extended immediates of each format
	assign imm_i = {{20{i_instruction[31]}}, i_instruction[31:20]};
	assign imm_s = {{20{i_instruction[31]}}, i_instruction[31:25], i_instruction[11:7]};
	assign imm_b = {{19{i_instruction[31]}}, i_instruction[31], i_instruction[7],
		i_instruction[30:25], i_instruction[11:8], 1'b0};
	assign imm_u = {i_instruction[31:12], 12'h000};
	assign imm_j = {{11{i_instruction[31]}}, i_instruction[31], i_instruction[19:12],
		i_instruction[20], i_instruction[30:21], 1'b0};

	always_comb begin
		o_decode = '0;
		o_decode.rd = i_instruction[11:7];
		o_decode.rs1 = i_instruction[19:15];
		o_decode.rs2 = i_instruction[24:20];
		o_decode.alu_op = ALU_ADD;
		case (opcode)
			OPC_LUI: begin
				o_decode.imm = imm_u;
				o_decode.alu_op = ALU_PASS_B;
				o_decode.use_imm = 1'b1;
				o_decode.reg_write = 1'b1;
			end
			OPC_OPIMM: begin
				o_decode.imm = imm_i;
				o_decode.use_imm = 1'b1;
				o_decode.reg_write = 1'b1;
				o_decode.illegal = (funct3 != 3'b000);
			end
			OPC_OP: begin
				o_decode.reg_write = 1'b1;
				o_decode.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
				o_decode.illegal = (funct3 != 3'b000) ||
					(funct7 != 7'b0000000 && funct7 != 7'b0100000);
			end
			OPC_LOAD: begin
				o_decode.imm = imm_i;
				o_decode.use_imm = 1'b1;
				o_decode.reg_write = 1'b1;
				o_decode.is_load = 1'b1;
				o_decode.illegal = (funct3 != 3'b010);
			end
			OPC_STORE: begin
				o_decode.imm = imm_s;
				o_decode.use_imm = 1'b1;
				o_decode.is_store = 1'b1;
				o_decode.illegal = (funct3 != 3'b010);
			end
			OPC_BRANCH: begin
				// Compare by subtraction, offset added to pc in the core
				o_decode.imm = imm_b;
				o_decode.alu_op = ALU_SUB;
				o_decode.is_branch = 1'b1;
				o_decode.illegal = (funct3 != 3'b000);
			end
			OPC_JAL: begin
				o_decode.imm = imm_j;
				o_decode.reg_write = 1'b1;
				o_decode.is_jal = 1'b1;
			end
			OPC_SYSTEM: begin
				o_decode.is_ecall = (i_instruction == 32'h0000_0073);
				o_decode.illegal = (i_instruction != 32'h0000_0073);
			end
			default: o_decode.illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
//==================================================
// Shared types and constants for the RV32I subset
// core, the bus arbiter and the word RAM.
// Modules import it inside their bodies.
//==================================================
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0] reg_idx_t;

	localparam addr_t RESET_VECTOR = 32'h0000_0000;
	// 1024 words of RAM
	localparam int RAM_ADDR_BITS = 10;

	// Major opcodes, instruction bits [6:0]
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_OPIMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// Request side of the plain request/ready bus
	typedef struct packed {
		logic rw;
		addr_t address;
		word_t wdata;
	} bus_req_t;

	typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_PASS_B} alu_op_e;

	typedef struct packed {
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		word_t imm;
		alu_op_e alu_op;
		logic use_imm;
		logic reg_write;
		logic is_load;
		logic is_store;
		logic is_branch;
		logic is_jal;
		logic is_ecall;
		logic illegal;
	} decode_t;

	typedef enum logic [2:0] {
		ST_FETCH, ST_EXECUTE, ST_MEMORY, ST_WRITEBACK, ST_HALT
	} core_state_e;

	typedef enum logic [1:0] {M_NONE, M_DBUS, M_IBUS, M_HOST} master_e;

endpackage

`default_nettype wire

// ==== cpu_registers.sv ====
//==================================================
// Integer register file, 32 x 32 bits.
// Two asynchronous read ports, one write port.
//==================================================
`timescale 1ns/1ps
`default_nettype none

module cpu_registers (
	input wire i_clock,
	input wire i_reset,
	input wire cpu_pkg::reg_idx_t i_rs1_idx,
	input wire cpu_pkg::reg_idx_t i_rs2_idx,
	output cpu_pkg::word_t o_rs1,
	output cpu_pkg::word_t o_rs2,
	input wire i_write,
	input wire cpu_pkg::reg_idx_t i_rd_idx,
	input wire cpu_pkg::word_t i_rd_data
);
	import cpu_pkg::*;

	word_t regs [0:31];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (i_write && i_rd_idx != '0) begin
			regs[i_rd_idx] <= i_rd_data;
		end
	end

	// x0 reads as zero whatever the array holds
	assign o_rs1 = (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
	assign o_rs2 = (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];

	a_write_idx_known: assert property (@(posedge i_clock) disable iff (i_reset)
		i_write |-> !$isunknown(i_rd_idx));

endmodule

`default_nettype wire

// ==== ram.sv ====
//==================================================
// Single-port word RAM on the request/ready bus.
// Answers a new request with a ready pulse on the
// next edge, read data valid with ready.
//==================================================
`timescale 1ns/1ps
`default_nettype none

module ram (
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire cpu_pkg::bus_req_t i_req,
	output logic o_ready,
	output cpu_pkg::word_t o_rdata
);
	import cpu_pkg::*;

	word_t mem [0:(1 << RAM_ADDR_BITS) - 1];
	logic [RAM_ADDR_BITS-1:0] word_idx;
	logic accept;

	assign word_idx = i_req.address[RAM_ADDR_BITS+1:2];
	// Request still high during its own ready cycle is not a new one
	assign accept = i_request && !o_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_ready <= 1'b0;
		else
			o_ready <= accept;
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			if (i_req.rw)
				mem[word_idx] <= i_req.wdata;
			else
				o_rdata <= mem[word_idx];
		end
	end

	a_req_held: assert property (@(posedge i_clock) disable iff (i_reset)
		i_request && !o_ready |=> i_request && $stable(i_req));

endmodule

`default_nettype wire

// ==== soc_top.sv ====
//==================================================
// System top: core, arbiter and RAM. The host port
// loads programs and reads results, and shares the
// RAM with the core.
//==================================================
`timescale 1ns/1ps
`default_nettype none

module soc_top (
	input wire i_clock,
	input wire i_reset,
	input wire i_run,

	// Host port
	input wire i_host_request,
	input wire cpu_pkg::bus_req_t i_host_req,
	output logic o_host_ready,
	output cpu_pkg::word_t o_host_rdata,

	// Debug
	output logic o_busy,
	output logic o_halted,
	output logic o_fault,
	output cpu_pkg::word_t o_retired
);
	import cpu_pkg::*;

	logic ibus_request;
	logic ibus_ready;
	bus_req_t ibus_req;
	word_t ibus_rdata;
	logic dbus_request;
	logic dbus_ready;
	bus_req_t dbus_req;
	word_t dbus_rdata;
	logic mem_request;
	logic mem_ready;
	bus_req_t mem_req;
	word_t mem_rdata;

	cpu_core core_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_run(i_run),
		.o_ibus_request(ibus_request),
		.i_ibus_ready(ibus_ready),
		.o_ibus_req(ibus_req),
		.i_ibus_rdata(ibus_rdata),
		.o_dbus_request(dbus_request),
		.i_dbus_ready(dbus_ready),
		.o_dbus_req(dbus_req),
		.i_dbus_rdata(dbus_rdata),
		.o_busy(o_busy),
		.o_halted(o_halted),
		.o_fault(o_fault),
		.o_retired(o_retired)
	);

	bus_arbiter arbiter_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_dbus_request(dbus_request),
		.i_dbus_req(dbus_req),
		.o_dbus_ready(dbus_ready),
		.o_dbus_rdata(dbus_rdata),
		.i_ibus_request(ibus_request),
		.i_ibus_req(ibus_req),
		.o_ibus_ready(ibus_ready),
		.o_ibus_rdata(ibus_rdata),
		.i_host_request(i_host_request),
		.i_host_req(i_host_req),
		.o_host_ready(o_host_ready),
		.o_host_rdata(o_host_rdata),
		.o_mem_request(mem_request),
		.o_mem_req(mem_req),
		.i_mem_ready(mem_ready),
		.i_mem_rdata(mem_rdata)
	);

	ram ram_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(mem_request),
		.i_req(mem_req),
		.o_ready(mem_ready),
		.o_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// ==== sources.f ====
cpu_pkg.sv
cpu_registers.sv
cpu_decode.sv
cpu_core.sv
bus_arbiter.sv
ram.sv
soc_top.sv
tb_soc.sv

// ==== tb_soc.sv ====
//==================================================
// Testbench for the processor system top level.
// Loads programs through the host port, runs the
// core to ECALL and checks memory and debug outputs.
//==================================================
`timescale 1ns/1ps
`default_nettype none

module tb_soc;
	import cpu_pkg::*;

	localparam int TIMEOUT_CYCLES = 20000;
	localparam word_t ECALL_INSN = 32'h0000_0073;
	// Custom-0 opcode, outside the subset
	localparam word_t UNDEFINED_INSN = 32'h0000_000B;

	logic clock;
	logic reset;
	logic run;
	logic host_request;
	bus_req_t host_req;
	logic host_ready;
	word_t host_rdata;
	logic busy;
	logic halted;
	logic fault;
	word_t retired;

	int cycles;
	word_t rng_state;
	word_t prog [$];
	// What the host last wrote, by word index
	word_t expect_mem [0:(1 << RAM_ADDR_BITS) - 1];

	soc_top soc_top_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_run(run),
		.i_host_request(host_request),
		.i_host_req(host_req),
		.o_host_ready(host_ready),
		.o_host_rdata(host_rdata),
		.o_busy(busy),
		.o_halted(halted),
		.o_fault(fault),
		.o_retired(retired)
	);

	always #20 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failures found");
			$fatal(1, "timeout");
		end
	end

	//==================================================
	// Random numbers and instruction encoders

	function automatic word_t xorshift32(input word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t random_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic word_t sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic word_t lui_insn(input reg_idx_t rd, input logic [19:0] imm);
		return {imm, rd, OPC_LUI};
	endfunction

	function automatic word_t addi_insn(input reg_idx_t rd, input reg_idx_t rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, OPC_OPIMM};
	endfunction

	function automatic word_t add_insn(input reg_idx_t rd, input reg_idx_t rs1,
		input reg_idx_t rs2);
		return {7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP};
	endfunction

	function automatic word_t sub_insn(input reg_idx_t rd, input reg_idx_t rs1,
		input reg_idx_t rs2);
		return {7'b0100000, rs2, rs1, 3'b000, rd, OPC_OP};
	endfunction

	function automatic word_t lw_insn(input reg_idx_t rd, input reg_idx_t rs1,
		input logic [11:0] off);
		return {off, rs1, 3'b010, rd, OPC_LOAD};
	endfunction

	function automatic word_t sw_insn(input reg_idx_t rs2, input reg_idx_t rs1,
		input logic [11:0] off);
		return {off[11:5], rs2, rs1, 3'b010, off[4:0], OPC_STORE};
	endfunction

	function automatic word_t beq_insn(input reg_idx_t rs1, input reg_idx_t rs2,
		input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic word_t jal_insn(input reg_idx_t rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	function automatic void append_insn(input word_t w);
		prog.push_back(w);
	endfunction

	//==================================================
	// Compare tasks

	task automatic check_word(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, actual, expected);
			$display("Test failures found");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, actual, expected);
			$display("Test failures found");
			$fatal(1, "flag mismatch");
		end
	endtask

	//==================================================
	// Host port and run control

	task automatic apply_reset();
		@(negedge clock);
		run = 1'b0;
		reset = 1'b1;
		repeat (10) @(negedge clock);
		reset = 1'b0;
		check_flag("o_busy", busy, 1'b0);
		check_flag("o_halted", halted, 1'b0);
		check_flag("o_fault", fault, 1'b0);
		check_word("o_retired", retired, 32'd0);
	endtask

	task automatic host_write(input addr_t address, input word_t data);
		@(negedge clock);
		host_request = 1'b1;
		host_req.rw = 1'b1;
		host_req.address = address;
		host_req.wdata = data;
		@(negedge clock);
		while (!host_ready) @(negedge clock);
		// Request stays up through the edge that samples ready
		@(negedge clock);
		host_request = 1'b0;
		expect_mem[address[RAM_ADDR_BITS+1:2]] = data;
	endtask

	task automatic host_read(input addr_t address, output word_t data);
		@(negedge clock);
		host_request = 1'b1;
		host_req.rw = 1'b0;
		host_req.address = address;
		host_req.wdata = '0;
		@(negedge clock);
		while (!host_ready) @(negedge clock);
		data = host_rdata;
		@(negedge clock);
		host_request = 1'b0;
	endtask

	task automatic read_and_check(input addr_t address, input word_t expected);
		word_t got;
		host_read(address, got);
		check_word($sformatf("o_host_rdata @ 0x%h", address), got, expected);
	endtask

	task automatic load_program();
		for (int i = 0; i < prog.size(); i++)
			host_write(addr_t'(i * 4), prog[i]);
	endtask

	task automatic run_until_halt();
		@(negedge clock);
		run = 1'b1;
		@(negedge clock);
		check_flag("o_busy", busy, 1'b1);
		while (!halted) @(negedge clock);
		run = 1'b0;
	endtask

	//==================================================
	// Directed tests

	task automatic host_roundtrip();
		addr_t addrs [16];
		word_t r;
		for (int i = 0; i < 16; i++) begin
			r = random_word();
			addrs[i] = {20'h0, r[9:0], 2'b00};
			host_write(addrs[i], random_word());
		end
		// Repeated addresses expect the last write
		for (int i = 0; i < 16; i++)
			read_and_check(addrs[i], expect_mem[addrs[i][RAM_ADDR_BITS+1:2]]);
	endtask

	task automatic alu_program();
		word_t r;
		logic [19:0] upper;
		logic [11:0] imm_a;
		logic [11:0] imm_b;
		word_t x1;
		word_t x2;
		word_t x3;
		r = random_word();
		upper = r[19:0];
		imm_a = r[31:20];
		r = random_word();
		imm_b = r[11:0];
		x1 = {upper, 12'h000};
		x2 = x1 + sext12(imm_a);
		x3 = sext12(imm_b);
		apply_reset();
		prog.delete();
		append_insn(lui_insn(1, upper));
		append_insn(addi_insn(2, 1, imm_a));
		append_insn(addi_insn(3, 0, imm_b));
		append_insn(add_insn(4, 2, 3));
		append_insn(sub_insn(5, 2, 3));
		append_insn(sw_insn(1, 0, 12'h400));
		append_insn(sw_insn(2, 0, 12'h404));
		append_insn(sw_insn(3, 0, 12'h408));
		append_insn(sw_insn(4, 0, 12'h40C));
		append_insn(sw_insn(5, 0, 12'h410));
		append_insn(ECALL_INSN);
		load_program();
		run_until_halt();
		check_flag("o_fault", fault, 1'b0);
		// ECALL halts without retiring
		check_word("o_retired", retired, word_t'(prog.size() - 1));
		read_and_check(32'h400, x1);
		read_and_check(32'h404, x2);
		read_and_check(32'h408, x3);
		read_and_check(32'h40C, x2 + x3);
		read_and_check(32'h410, x2 - x3);
	endtask

	task automatic load_store_sum();
		word_t a;
		word_t b;
		word_t c;
		a = random_word();
		b = random_word();
		c = random_word();
		apply_reset();
		host_write(32'h500, a);
		host_write(32'h504, b);
		host_write(32'h508, 32'h0);
		host_write(32'h50C, c);
		prog.delete();
		append_insn(lw_insn(1, 0, 12'h500));
		append_insn(lw_insn(2, 0, 12'h504));
		append_insn(add_insn(3, 1, 2));
		append_insn(sw_insn(3, 0, 12'h508));
		append_insn(ECALL_INSN);
		load_program();
		run_until_halt();
		check_word("o_retired", retired, 32'd4);
		read_and_check(32'h508, a + b);
		read_and_check(32'h500, a);
		read_and_check(32'h504, b);
		read_and_check(32'h50C, c);
	endtask

	task automatic loop_and_jump();
		word_t r;
		int n;
		r = random_word();
		n = int'(r[2:0]) + 1;
		apply_reset();
		host_write(32'h600, 32'h0);
		host_write(32'h604, 32'hDEAD_BEEF);
		prog.delete();
		append_insn(addi_insn(1, 0, 12'h000));
		append_insn(addi_insn(2, 0, 12'(n)));
		// Loop body at 0x08, exit to 0x14
		append_insn(addi_insn(1, 1, 12'h001));
		append_insn(beq_insn(1, 2, 13'd8));
		append_insn(jal_insn(0, 21'h1F_FFF8));
		append_insn(jal_insn(0, 21'd8));
		append_insn(sw_insn(2, 0, 12'h604));
		append_insn(sw_insn(1, 0, 12'h600));
		append_insn(ECALL_INSN);
		load_program();
		run_until_halt();
		// Two setup, three per pass less the last jump back, jump and store
		check_word("o_retired", retired, word_t'(3 * n + 3));
		read_and_check(32'h600, word_t'(n));
		read_and_check(32'h604, 32'hDEAD_BEEF);
	endtask

	task automatic illegal_opcode_fault();
		apply_reset();
		prog.delete();
		append_insn(addi_insn(1, 0, 12'd5));
		append_insn(addi_insn(2, 0, 12'd7));
		append_insn(UNDEFINED_INSN);
		append_insn(ECALL_INSN);
		load_program();
		run_until_halt();
		check_flag("o_fault", fault, 1'b1);
		check_flag("o_busy", busy, 1'b0);
		check_word("o_retired", retired, 32'd2);
	endtask

	task automatic host_contention();
		word_t fixed;
		word_t sum;
		word_t r;
		fixed = random_word();
		sum = '0;
		apply_reset();
		host_write(32'h700, fixed);
		host_write(32'h704, 32'h0);
		prog.delete();
		append_insn(addi_insn(1, 0, 12'h000));
		for (int i = 0; i < 40; i++) begin
			r = random_word();
			append_insn(addi_insn(1, 1, {6'b0, r[5:0]}));
			sum = sum + {26'b0, r[5:0]};
		end
		append_insn(sw_insn(1, 0, 12'h704));
		append_insn(ECALL_INSN);
		load_program();
		fork
			run_until_halt();
			repeat (20) read_and_check(32'h700, fixed);
		join
		check_word("o_retired", retired, 32'd42);
		read_and_check(32'h704, sum);
	endtask

	//==================================================
	// Main sequence

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		run = 1'b0;
		host_request = 1'b0;
		host_req = '0;
		cycles = 0;
		rng_state = 32'd52;
		apply_reset();
		host_roundtrip();
		alu_program();
		load_store_sum();
		loop_and_jump();
		illegal_opcode_fault();
		host_contention();
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire
